//--- build.f
+incdir+verilog
verilog/hl_pkg.sv
verilog/cmd_decoder.sv
verilog/tr_control.sv
verilog/ad9866_spi.sv
verilog/status_report.sv
verilog/resp_arbiter.sv
verilog/hl_core.sv
testbench/hl_core_properties.sv
testbench/tb_hl_core.sv

//--- testbench/hl_core_properties.sv
`timescale 1ns/10ps
`default_nettype none

module hl_core_properties (
  input logic clk_ctrl,
  input logic rst_i,
  input logic echo_gnt_i,
  input logic status_gnt_i,
  input logic run_i,
  input logic tx_on_i,
  input logic spi_busy_i,
  input logic sen_n_i,
  input logic resp_valid_i
);

  // count of failed assertions
  int fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // arbiter
  ////////////////////////////////////////////////////////////

  a_one_grant : assert property (@(posedge clk_ctrl) disable iff (rst_i)
    !(echo_gnt_i && status_gnt_i))
  else begin
    $error("echo and status granted in the same cycle");
    fail_cnt++;
  end

  // at most one response word per two cycles
  a_valid_pulse : assert property (@(posedge clk_ctrl) disable iff (rst_i)
    resp_valid_i |=> !resp_valid_i)
  else begin
    $error("resp_valid_o high for two cycles in a row");
    fail_cnt++;
  end

  ////////////////////////////////////////////////////////////
  // peers
  ////////////////////////////////////////////////////////////

  a_tx_needs_run : assert property (@(posedge clk_ctrl) disable iff (rst_i)
    tx_on_i |-> run_i)
  else begin
    $error("tx_on high while run is low");
    fail_cnt++;
  end

  a_sen_in_frame : assert property (@(posedge clk_ctrl) disable iff (rst_i)
    !sen_n_i |-> spi_busy_i)
  else begin
    $error("sen_n low while the serial port is idle");
    fail_cnt++;
  end

endmodule

bind hl_core hl_core_properties u_props (
  .clk_ctrl     (clk_ctrl),
  .rst_i        (rst_i),
  .echo_gnt_i   (echo_gnt),
  .status_gnt_i (status_gnt),
  .run_i        (run),
  .tx_on_i      (tx_on),
  .spi_busy_i   (spi_busy),
  .sen_n_i      (rffe_ad9866_sen_n_o),
  .resp_valid_i (resp_valid_o)
);

`default_nettype wire

//--- testbench/tb_hl_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "hl_defines.svh"

module tb_hl_core;

  localparam int TIMEOUT_CYC = 20000;
  localparam int PERIOD      = `HL_STATUS_PERIOD;
  // clk_ctrl cycles of one serial frame
  localparam int SPI_CYC     = 16 * 2 * `HL_SPI_DIV;

  logic                  clk_ctrl;
  logic                  rst_i;
  logic                  ds_valid_i;
  logic                  ds_first_i;
  logic [7:0]            ds_data_i;
  logic                  io_tx_inhibit_i;
  logic [`HL_RESP_W-1:0] resp_o;
  logic                  resp_valid_o;
  logic                  io_led_run_o;
  logic                  io_led_tx_o;
  logic                  pa_inttr_o;
  logic                  rffe_ad9866_sclk_o;
  logic                  rffe_ad9866_sdio_o;
  logic                  rffe_ad9866_sen_n_o;

  int seed = 4392;
  int cyc  = 0;
  // cycle count of the last reset edge
  int base = 0;
  bit rst_done = 1'b0;

  // expected responses in output order, with the cycle each is due
  logic [`HL_RESP_W-1:0] exp_word_q[$];
  int                    exp_cyc_q[$];
  logic [15:0]           frame_q[$];
  logic [15:0]           frame_sr;
  int                    frame_bits;

  // state model
  logic        run_m;
  logic        mox_m;
  logic        inh_m;
  logic [15:0] seq_m;
  int          spi_start;
  int          last_drive_cyc;

  hl_core u_hl_core (
    .clk_ctrl            (clk_ctrl),
    .rst_i               (rst_i),
    .ds_valid_i          (ds_valid_i),
    .ds_first_i          (ds_first_i),
    .ds_data_i           (ds_data_i),
    .io_tx_inhibit_i     (io_tx_inhibit_i),
    .resp_o              (resp_o),
    .resp_valid_o        (resp_valid_o),
    .io_led_run_o        (io_led_run_o),
    .io_led_tx_o         (io_led_tx_o),
    .pa_inttr_o          (pa_inttr_o),
    .rffe_ad9866_sclk_o  (rffe_ad9866_sclk_o),
    .rffe_ad9866_sdio_o  (rffe_ad9866_sdio_o),
    .rffe_ad9866_sen_n_o (rffe_ad9866_sen_n_o)
  );

  always #2 clk_ctrl = ~clk_ctrl;

  always @(posedge clk_ctrl) begin
    cyc <= cyc + 1;
  end

  always @(posedge clk_ctrl) begin
    if (cyc >= TIMEOUT_CYC) begin
      $display("run timed out after %0d cycles", cyc);
      $display("tests failed");
      $fatal(1, "timeout");
    end
  end

  // bound checker failures end the run at once
  always @(negedge clk_ctrl) begin
    if (u_hl_core.u_props.fail_cnt != 0) begin
      $display("an assertion of the bound checker failed");
      $display("tests failed");
      $fatal(1, "assertion failure");
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // header byte: echo flag, zero bit, command address
  function automatic logic [`HL_RESP_W-1:0] ref_resp(input logic echo, input logic [5:0] addr,
                                                     input logic [31:0] data);
    return {echo, 1'b0, addr, data};
  endfunction

  function automatic logic ref_tx_on(input logic run, input logic mox, input logic inh);
    return run & mox & ~inh;
  endfunction

  task automatic check_val(input string name, input logic [39:0] exp_v,
                           input logic [39:0] got_v);
    if (got_v !== exp_v) begin
      $display("[ERROR] %s exp=%h got=%h", name, exp_v, got_v);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // status word snapshot taken on the tick edge
  task automatic push_status();
    logic        busy;
    logic [31:0] state;
    int          due;
    busy  = (cyc - 1 >= spi_start) && (cyc - 1 < spi_start + SPI_CYC);
    state = {seq_m, 12'h000, busy, inh_m, ref_tx_on(run_m, mox_m, inh_m), run_m};
    due   = cyc + 1;
    // echo due in the same cycle wins, status waits one free cycle
    if (exp_cyc_q.size() > 0 && exp_cyc_q[$] == cyc + 1) begin
      due = cyc + 3;
    end
    exp_word_q.push_back(ref_resp(1'b0, 6'h00, state));
    exp_cyc_q.push_back(due);
    seq_m = seq_m + 16'd1;
  endtask

  always @(negedge clk_ctrl) begin
    if (rst_done && cyc > base && (cyc - base) % PERIOD == 0) begin
      push_status();
    end
  end

  // response monitor
  always @(negedge clk_ctrl) begin
    if (rst_done && resp_valid_o === 1'b1) begin
      if (exp_word_q.size() == 0) begin
        $display("a response came out while none was expected");
        $display("tests failed");
        $fatal(1, "unexpected response");
      end else begin
        check_val("resp_o", exp_word_q.pop_front(), resp_o);
        check_val("resp_valid_o cycle", exp_cyc_q.pop_front(), cyc);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // serial frame capture
  ////////////////////////////////////////////////////////////

  always @(negedge rffe_ad9866_sen_n_o) begin
    frame_bits = 0;
  end

  always @(posedge rffe_ad9866_sclk_o) begin
    if (!rffe_ad9866_sen_n_o) begin
      frame_sr   = {frame_sr[14:0], rffe_ad9866_sdio_o};
      frame_bits = frame_bits + 1;
    end
  end

  always @(posedge rffe_ad9866_sen_n_o) begin
    if (rst_done) begin
      check_val("frame length", 40'd16, frame_bits);
      frame_q.push_back(frame_sr);
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_ctrl);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic put_byte(input logic first, input logic [7:0] b);
    ds_valid_i = 1'b1;
    ds_first_i = first;
    ds_data_i  = b;
    next_cycle();
    ds_valid_i = 1'b0;
    ds_first_i = 1'b0;
  endtask

  task automatic send_cmd(input logic flag, input logic [5:0] addr, input logic [31:0] data,
                          input int max_gap);
    logic [7:0] bytes [5];
    int         gap;
    bytes[0] = {flag, 1'b0, addr};
    bytes[1] = data[31:24];
    bytes[2] = data[23:16];
    bytes[3] = data[15:8];
    bytes[4] = data[7:0];
    for (int i = 0; i < 5; i++) begin
      if (i == 4) begin
        last_drive_cyc = cyc;
        if (flag) begin
          exp_word_q.push_back(ref_resp(1'b1, addr, data));
          exp_cyc_q.push_back(cyc + 2);
        end
      end
      put_byte(i == 0, bytes[i]);
      if (i < 4 && max_gap > 0) begin
        gap = {$random(seed)} % (max_gap + 1);
        wait_cycles(gap);
      end
    end
    if (addr == `HL_ADDR_CTRL) begin
      run_m = data[0];
      mox_m = data[1];
    end
  endtask

  // keep state changes away from the status snapshot
  task automatic keep_clear(input int n);
    int phase;
    phase = (cyc - base) % PERIOD;
    while (phase < 6 || PERIOD - phase < n + 6) begin
      next_cycle();
      phase = (cyc - base) % PERIOD;
    end
  endtask

  task automatic wait_phase(input int p);
    while ((cyc - base) % PERIOD != p) next_cycle();
  endtask

  task automatic check_leds();
    check_val("io_led_run_o", run_m, io_led_run_o);
    check_val("io_led_tx_o", ref_tx_on(run_m, mox_m, inh_m), io_led_tx_o);
    check_val("pa_inttr_o", ref_tx_on(run_m, mox_m, inh_m), pa_inttr_o);
  endtask

  task automatic wait_frame(input logic [15:0] exp_frame);
    while (frame_q.size() == 0) next_cycle();
    check_val("spi frame", exp_frame, frame_q.pop_front());
  endtask

  initial begin
    logic [5:0]  a;
    logic [31:0] d;
    logic [31:0] d2;
    clk_ctrl        = 1'b0;
    rst_i           = 1'b1;
    ds_valid_i      = 1'b0;
    ds_first_i      = 1'b0;
    ds_data_i       = 8'h00;
    io_tx_inhibit_i = 1'b0;
    run_m           = 1'b0;
    mox_m           = 1'b0;
    inh_m           = 1'b0;
    seq_m           = 16'h0000;
    spi_start       = -1000;
    frame_bits      = 0;
    frame_sr        = 16'h0000;
    repeat (10) @(posedge clk_ctrl);
    #1;
    rst_i    = 1'b0;
    base     = cyc;
    rst_done = 1'b1;

    // idle state after reset
    check_val("resp_valid_o", 1'b0, resp_valid_o);
    check_val("rffe_ad9866_sen_n_o", 1'b1, rffe_ad9866_sen_n_o);
    check_leds();

    // echoes to addresses no peer uses
    for (int i = 0; i < 10; i++) begin
      a = 6'($random(seed));
      if (a == `HL_ADDR_CTRL || a == `HL_ADDR_SPI) a = 6'h2a;
      keep_clear(24);
      send_cmd(1'b1, a, $random(seed), i % 3);
    end

    // run/mox with the inhibit pin toggled
    for (int i = 0; i < 16; i++) begin
      keep_clear(24);
      send_cmd(1'($random(seed)), `HL_ADDR_CTRL, $random(seed), 1);
      wait_cycles(3);
      check_leds();
      if (i % 3 == 1) begin
        keep_clear(8);
        io_tx_inhibit_i = ~io_tx_inhibit_i;
        inh_m           = io_tx_inhibit_i;
        wait_cycles(3);
        check_leds();
      end
    end

    // converter writes, busy window is free to overlap a status tick
    for (int i = 0; i < 5; i++) begin
      d = $random(seed);
      send_cmd(1'b0, `HL_ADDR_SPI, d, 1);
      spi_start = last_drive_cyc + 2;
      wait_frame(d[15:0]);
    end
    d  = $random(seed);
    d2 = $random(seed);
    send_cmd(1'b0, `HL_ADDR_SPI, d, 0);
    spi_start = last_drive_cyc + 2;
    // lands while the first frame is still shifting
    send_cmd(1'b0, `HL_ADDR_SPI, d2, 0);
    wait_frame(d[15:0]);
    wait_cycles(2 * SPI_CYC);
    check_val("frames after dropped write", 40'd0, frame_q.size());

    // ds_first_i in mid command
    keep_clear(40);
    put_byte(1'b1, {1'b1, 1'b0, `HL_ADDR_CTRL});
    put_byte(1'b0, 8'hff);
    put_byte(1'b0, 8'hff);
    put_byte(1'b0, 8'hff);
    send_cmd(1'b1, 6'h11, $random(seed), 0);
    wait_cycles(3);
    check_leds();

    // fifth byte sampled on the status tick edge
    wait_phase(PERIOD - 5);
    send_cmd(1'b1, 6'h15, $random(seed), 0);

    wait_cycles(2 * PERIOD);
    while (exp_word_q.size() != 0) next_cycle();

    if (u_hl_core.u_props.fail_cnt != 0) begin
      $display("%0d assertion failures during the run", u_hl_core.u_props.fail_cnt);
      $display("tests failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ad9866_spi.sv
`timescale 1ns/10ps
`default_nettype none

`include "hl_defines.svh"

module ad9866_spi (
  input  logic                      clk_ctrl,
  input  logic                      rst_i,
  input  logic [`HL_CMD_ADDR_W-1:0] cmd_addr_i,
  input  hl_pkg::cmd_payload_u      cmd_data_i,
  input  logic                      cmd_stb_i,
  output logic                      busy_o,
  output logic                      rffe_ad9866_sclk_o,
  output logic                      rffe_ad9866_sdio_o,
  output logic                      rffe_ad9866_sen_n_o
);

  localparam int DIV_W = (`HL_SPI_DIV > 1) ? $clog2(`HL_SPI_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       bit_cnt;
  logic [15:0]      frame_sr;
  logic             busy_q;
  logic             sclk_q;
  logic             sen_n_q;
  logic             spi_wr;
  logic             half_done;

  // writes while busy are dropped
  assign spi_wr    = cmd_stb_i & (cmd_addr_i == `HL_ADDR_SPI) & ~busy_q;
  assign half_done = (div_cnt == DIV_W'(`HL_SPI_DIV - 1));

  ////////////////////////////////////////////////////////////
  // frame shifter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      busy_q   <= 1'b0;
      sclk_q   <= 1'b0;
      sen_n_q  <= 1'b1;
      div_cnt  <= '0;
      bit_cnt  <= 4'd0;
      frame_sr <= 16'h0000;
    end else if (spi_wr) begin
      busy_q   <= 1'b1;
      sen_n_q  <= 1'b0;
      sclk_q   <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= 4'd0;
      // register address goes out first
      frame_sr <= {cmd_data_i.spi.reg_addr, cmd_data_i.spi.reg_val};
    end else if (busy_q) begin
      div_cnt <= half_done ? '0 : div_cnt + 1'b1;
      if (half_done) begin
        sclk_q <= ~sclk_q;
        // falling sclk closes a bit, next bit set up while low
        if (sclk_q) begin
          frame_sr <= {frame_sr[14:0], 1'b0};
          bit_cnt  <= bit_cnt + 4'd1;
          if (bit_cnt == 4'd15) begin
            busy_q  <= 1'b0;
            sen_n_q <= 1'b1;
          end
        end
      end
    end
  end

  assign busy_o              = busy_q;
  assign rffe_ad9866_sclk_o  = sclk_q;
  assign rffe_ad9866_sdio_o  = frame_sr[15];
  assign rffe_ad9866_sen_n_o = sen_n_q;

endmodule

`default_nettype wire

//--- verilog/cmd_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "hl_defines.svh"

module cmd_decoder (
  input  logic                      clk_ctrl,
  input  logic                      rst_i,
  input  logic                      ds_valid_i,
  input  logic                      ds_first_i,
  input  logic [7:0]                ds_data_i,
  output logic [`HL_CMD_ADDR_W-1:0] cmd_addr_o,
  output hl_pkg::cmd_payload_u      cmd_data_o,
  output logic                      cmd_stb_o,
  input  logic                      echo_gnt_i,
  output logic                      echo_req_o,
  output logic [`HL_RESP_W-1:0]     echo_word_o
);

  // byte position, 0 means waiting for a first byte
  logic [2:0]                byte_cnt;
  logic                      resp_flag;
  logic [`HL_CMD_ADDR_W-1:0] addr_q;
  // bytes 1 to 3, MSB first
  logic [23:0]               data_sr;
  logic                      last_byte;
  hl_pkg::resp_hdr_t         echo_hdr;

  assign last_byte = ds_valid_i & ~ds_first_i & (byte_cnt == 3'd4);

  always_comb begin
    echo_hdr      = '0;
    echo_hdr.echo = 1'b1;
    echo_hdr.addr = addr_q;
  end

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      byte_cnt   <= 3'd0;
      cmd_stb_o  <= 1'b0;
      echo_req_o <= 1'b0;
    end else begin
      cmd_stb_o <= last_byte;
      // a first byte always restarts, partial bytes are dropped
      if (ds_valid_i && ds_first_i) begin
        byte_cnt <= 3'd1;
      end else if (ds_valid_i && byte_cnt != 3'd0) begin
        byte_cnt <= last_byte ? 3'd0 : byte_cnt + 3'd1;
      end
      // held until the arbiter grants it
      if (last_byte && resp_flag) begin
        echo_req_o <= 1'b1;
      end else if (echo_gnt_i) begin
        echo_req_o <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (ds_valid_i && ds_first_i) begin
      resp_flag <= ds_data_i[7];
      addr_q    <= ds_data_i[`HL_CMD_ADDR_W-1:0];
    end else if (ds_valid_i && byte_cnt != 3'd0) begin
      data_sr <= {data_sr[15:0], ds_data_i};
    end
    if (last_byte) begin
      cmd_addr_o     <= addr_q;
      cmd_data_o.raw <= {data_sr, ds_data_i};
      echo_word_o    <= {echo_hdr, data_sr, ds_data_i};
    end
  end

endmodule

`default_nettype wire

//--- verilog/hl_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "hl_defines.svh"

module hl_core (
  input  logic                  clk_ctrl,
  input  logic                  rst_i,
  input  logic                  ds_valid_i,
  input  logic                  ds_first_i,
  input  logic [7:0]            ds_data_i,
  input  logic                  io_tx_inhibit_i,
  output logic [`HL_RESP_W-1:0] resp_o,
  output logic                  resp_valid_o,
  output logic                  io_led_run_o,
  output logic                  io_led_tx_o,
  output logic                  pa_inttr_o,
  output logic                  rffe_ad9866_sclk_o,
  output logic                  rffe_ad9866_sdio_o,
  output logic                  rffe_ad9866_sen_n_o
);

  // command bus
  logic [`HL_CMD_ADDR_W-1:0] cmd_addr;
  hl_pkg::cmd_payload_u      cmd_data;
  logic                      cmd_stb;

  // response requesters
  logic                  echo_req;
  logic                  echo_gnt;
  logic [`HL_RESP_W-1:0] echo_word;
  logic                  status_req;
  logic                  status_gnt;
  logic [`HL_RESP_W-1:0] status_word;

  // state seen by the status report
  logic run;
  logic tx_on;
  logic spi_busy;

  ////////////////////////////////////////////////////////////
  // command path
  ////////////////////////////////////////////////////////////

  cmd_decoder u_cmd_decoder (
    .clk_ctrl    (clk_ctrl),
    .rst_i       (rst_i),
    .ds_valid_i  (ds_valid_i),
    .ds_first_i  (ds_first_i),
    .ds_data_i   (ds_data_i),
    .cmd_addr_o  (cmd_addr),
    .cmd_data_o  (cmd_data),
    .cmd_stb_o   (cmd_stb),
    .echo_gnt_i  (echo_gnt),
    .echo_req_o  (echo_req),
    .echo_word_o (echo_word)
  );

  tr_control u_tr_control (
    .clk_ctrl        (clk_ctrl),
    .rst_i           (rst_i),
    .cmd_addr_i      (cmd_addr),
    .cmd_data_i      (cmd_data),
    .cmd_stb_i       (cmd_stb),
    .io_tx_inhibit_i (io_tx_inhibit_i),
    .run_o           (run),
    .tx_on_o         (tx_on),
    .io_led_run_o    (io_led_run_o),
    .io_led_tx_o     (io_led_tx_o),
    .pa_inttr_o      (pa_inttr_o)
  );

  ad9866_spi u_ad9866_spi (
    .clk_ctrl            (clk_ctrl),
    .rst_i               (rst_i),
    .cmd_addr_i          (cmd_addr),
    .cmd_data_i          (cmd_data),
    .cmd_stb_i           (cmd_stb),
    .busy_o              (spi_busy),
    .rffe_ad9866_sclk_o  (rffe_ad9866_sclk_o),
    .rffe_ad9866_sdio_o  (rffe_ad9866_sdio_o),
    .rffe_ad9866_sen_n_o (rffe_ad9866_sen_n_o)
  );

  ////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////

  status_report #(
    .PERIOD (`HL_STATUS_PERIOD)
  ) u_status_report (
    .clk_ctrl        (clk_ctrl),
    .rst_i           (rst_i),
    .run_i           (run),
    .tx_on_i         (tx_on),
    .io_tx_inhibit_i (io_tx_inhibit_i),
    .spi_busy_i      (spi_busy),
    .status_gnt_i    (status_gnt),
    .status_req_o    (status_req),
    .status_word_o   (status_word)
  );

  resp_arbiter u_resp_arbiter (
    .clk_ctrl      (clk_ctrl),
    .rst_i         (rst_i),
    .echo_req_i    (echo_req),
    .echo_word_i   (echo_word),
    .status_req_i  (status_req),
    .status_word_i (status_word),
    .echo_gnt_o    (echo_gnt),
    .status_gnt_o  (status_gnt),
    .resp_o        (resp_o),
    .resp_valid_o  (resp_valid_o)
  );

endmodule

`default_nettype wire

//--- verilog/hl_defines.svh
`ifndef HL_DEFINES_SVH
`define HL_DEFINES_SVH

////////////////////////////////////////////////////////////
// command bus widths
////////////////////////////////////////////////////////////

// address field of byte 0
`define HL_CMD_ADDR_W 6

// data word, bytes 1 to 4
`define HL_CMD_DATA_W 32

// header byte plus data word
`define HL_RESP_W 40

////////////////////////////////////////////////////////////
// command addresses
////////////////////////////////////////////////////////////

// run and mox bits
`define HL_ADDR_CTRL 6'h00

// converter register write
`define HL_ADDR_SPI 6'h3b

////////////////////////////////////////////////////////////
// timing
////////////////////////////////////////////////////////////

// clk_ctrl cycles per half serial clock
`define HL_SPI_DIV 2

// cycles between two status reports
`define HL_STATUS_PERIOD 256

`endif

//--- verilog/hl_pkg.sv
`default_nettype none

`include "hl_defines.svh"

package hl_pkg;

  ////////////////////////////////////////////////////////////
  // command payload
  ////////////////////////////////////////////////////////////

  // converter write, only the low half word is sent
  typedef struct packed {
    logic [15:0] unused;
    logic [7:0]  reg_addr;
    logic [7:0]  reg_val;
  } spi_fields_t;

  // one data word, two readings of it
  typedef union packed {
    logic [`HL_CMD_DATA_W-1:0] raw;
    spi_fields_t               spi;
  } cmd_payload_u;

  ////////////////////////////////////////////////////////////
  // response header
  ////////////////////////////////////////////////////////////

  // echo set for a command echo, clear for status
  typedef struct packed {
    logic                      echo;
    logic                      zero;
    logic [`HL_CMD_ADDR_W-1:0] addr;
  } resp_hdr_t;

endpackage

`default_nettype wire

//--- verilog/resp_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "hl_defines.svh"

module resp_arbiter (
  input  logic                  clk_ctrl,
  input  logic                  rst_i,
  input  logic                  echo_req_i,
  input  logic [`HL_RESP_W-1:0] echo_word_i,
  input  logic                  status_req_i,
  input  logic [`HL_RESP_W-1:0] status_word_i,
  output logic                  echo_gnt_o,
  output logic                  status_gnt_o,
  output logic [`HL_RESP_W-1:0] resp_o,
  output logic                  resp_valid_o
);

  ////////////////////////////////////////////////////////////
  // grant
  ////////////////////////////////////////////////////////////

  // echo always wins, it keeps its fixed response latency
  assign echo_gnt_o = echo_req_i;

  // status takes a free cycle, one that does not directly
  // follow another response
  assign status_gnt_o = status_req_i & ~echo_req_i & ~resp_valid_o;

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= echo_gnt_o | status_gnt_o;
    end
  end

  // word is latched on its grant
  always_ff @(posedge clk_ctrl) begin
    if (echo_gnt_o) begin
      resp_o <= echo_word_i;
    end else if (status_gnt_o) begin
      resp_o <= status_word_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/status_report.sv
`timescale 1ns/10ps
`default_nettype none

`include "hl_defines.svh"

module status_report #(
  parameter int PERIOD = `HL_STATUS_PERIOD
) (
  input  logic                  clk_ctrl,
  input  logic                  rst_i,
  input  logic                  run_i,
  input  logic                  tx_on_i,
  input  logic                  io_tx_inhibit_i,
  input  logic                  spi_busy_i,
  input  logic                  status_gnt_i,
  output logic                  status_req_o,
  output logic [`HL_RESP_W-1:0] status_word_o
);

  localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

  logic [CNT_W-1:0] period_cnt;
  logic [15:0]      seq_q;
  logic             tick;

  assign tick = (period_cnt == CNT_W'(PERIOD - 1));

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      period_cnt   <= '0;
      seq_q        <= 16'h0000;
      status_req_o <= 1'b0;
    end else begin
      period_cnt <= tick ? '0 : period_cnt + 1'b1;
      if (tick) begin
        status_req_o <= 1'b1;
      end else if (status_gnt_i) begin
        status_req_o <= 1'b0;
      end
      // next report gets the next number
      if (status_gnt_i) begin
        seq_q <= seq_q + 16'd1;
      end
    end
  end

  // snapshot of the state word
  always_ff @(posedge clk_ctrl) begin
    if (tick) begin
      // status carries an all zero header
      status_word_o <= {8'h00, seq_q, 12'h000,
                        spi_busy_i, io_tx_inhibit_i, tx_on_i, run_i};
    end
  end

endmodule

`default_nettype wire

//--- verilog/tr_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "hl_defines.svh"

module tr_control (
  input  logic                      clk_ctrl,
  input  logic                      rst_i,
  input  logic [`HL_CMD_ADDR_W-1:0] cmd_addr_i,
  input  hl_pkg::cmd_payload_u      cmd_data_i,
  input  logic                      cmd_stb_i,
  input  logic                      io_tx_inhibit_i,
  output logic                      run_o,
  output logic                      tx_on_o,
  output logic                      io_led_run_o,
  output logic                      io_led_tx_o,
  output logic                      pa_inttr_o
);

  logic run_q;
  logic mox_q;
  logic tx_on_q;
  // two flop synchronizer on the inhibit pin
  logic inh_meta;
  logic inh_sync;
  logic ctrl_wr;
  logic run_d;
  logic mox_d;

  assign ctrl_wr = cmd_stb_i & (cmd_addr_i == `HL_ADDR_CTRL);

  // next register values, tx_on is built from these
  assign run_d = ctrl_wr ? cmd_data_i.raw[0] : run_q;
  assign mox_d = ctrl_wr ? cmd_data_i.raw[1] : mox_q;

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      run_q    <= 1'b0;
      mox_q    <= 1'b0;
      tx_on_q  <= 1'b0;
      inh_meta <= 1'b0;
      inh_sync <= 1'b0;
    end else begin
      inh_meta <= io_tx_inhibit_i;
      inh_sync <= inh_meta;
      run_q    <= run_d;
      mox_q    <= mox_d;
      // transmit only when running, keyed and not inhibited
      tx_on_q  <= run_d & mox_d & ~inh_sync;
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  assign run_o   = run_q;
  assign tx_on_o = tx_on_q;

  // LEDs active high
  assign io_led_run_o = run_q;
  assign io_led_tx_o  = tx_on_q;

  // PA T/R switch follows tx_on
  assign pa_inttr_o = tx_on_q;

endmodule

`default_nettype wire
